/* alignPkg.sv */
`default_nettype none

package alignPkg;

    // request size as carried on the sizeIn pins
    typedef enum logic [1:0] {
        sz1 = 2'd0,
        sz2 = 2'd1,
        sz4 = 2'd2,
        sz8 = 2'd3
    } accessSize;

    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } accessOp;

    // cache line geometry
    localparam int lineBytes = 16;
    localparam int offsetBits = 4;
    localparam int dataBits = lineBytes * 8;

    // byte counts run 0..16, so one bit wider than the offset
    localparam int countBits = offsetBits + 1;

    // physical line space is 3 frame bits over a 4 KB page
    localparam int physAddrBits = 15;

endpackage

`default_nettype wire

/* tlbPkg.sv */
`default_nettype none

package tlbPkg;

    localparam int tlbEntries = 8;
    localparam int tlbIndexBits = 3;

    // 4 KB pages over a 32-bit virtual space
    localparam int pageOffsetBits = 12;
    localparam int vpnBits = 32 - pageOffsetBits;

    // only eight physical frames exist
    localparam int pfnBits = 3;

    // one translation, 27 bits
    typedef struct packed {
        logic [vpnBits-1:0] vpn;
        logic [pfnBits-1:0] pfn;
        logic               valid;
        logic               present;
        logic               writable;
        logic               cacheDisable;
    } tlbEntry;

endpackage

`default_nettype wire

/* accessIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface accessIf import alignPkg::*; ();

    logic                  valid;
    // line-aligned address of the first line
    logic [31:0]           vAddr0;
    // next line, vAddr0 + 16
    logic [31:0]           vAddr1;
    logic [offsetBits-1:0] offset;
    logic                  split;
    accessSize             size0;
    logic [countBits-1:0]  bytes0;
    logic [countBits-1:0]  bytes1;
    accessOp               op;
    logic                  fromBus;
    logic [dataBits-1:0]   data;

    modport decode (
        output valid, vAddr0, vAddr1, offset, split, size0,
               bytes0, bytes1, op, fromBus, data
    );

    // translation only needs the page numbers and the operation
    modport execute (
        input valid, vAddr0, vAddr1, split, op
    );

    modport result (
        input valid, vAddr0, vAddr1, offset, split, size0,
              bytes0, bytes1, op, fromBus, data
    );

endinterface

`default_nettype wire

/* accessDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module accessDecode import alignPkg::*; (
    input  logic                validIn,
    input  logic [31:0]         addressIn,
    input  accessSize           sizeIn,
    input  logic                sizeOvr,
    input  logic                write,
    input  logic                fromBus,
    input  logic [dataBits-1:0] dataIn,
    accessIf.decode             acc
);

    accessSize             effSize;
    logic [countBits-1:0]  byteCount;
    logic [offsetBits-1:0] offset;
    logic [countBits-1:0]  endSum;
    logic [countBits-1:0]  room;
    logic [31:0]           lineBase;
    logic                  split;

    // override always widens to a doubleword
    assign effSize = sizeOvr ? sz8 : sizeIn;

    always_comb begin
        case (effSize)
            sz1:     byteCount = countBits'(1);
            sz2:     byteCount = countBits'(2);
            sz4:     byteCount = countBits'(4);
            default: byteCount = countBits'(8);
        endcase
    end

    assign offset = addressIn[offsetBits-1:0];
    assign lineBase = {addressIn[31:offsetBits], {offsetBits{1'b0}}};

    // at most 15 + 8, fits the count width
    assign endSum = countBits'(offset) + byteCount;

    // bytes left before the line boundary
    assign room = countBits'(lineBytes) - countBits'(offset);

    // bus transfers are line sized and never cross
    assign split = !fromBus && (endSum > countBits'(lineBytes));

    assign acc.valid = validIn;
    assign acc.vAddr0 = lineBase;
    assign acc.vAddr1 = lineBase + 32'(lineBytes);
    assign acc.offset = offset;
    assign acc.split = split;
    assign acc.size0 = effSize;

    // first line takes what fits, the second the rest
    assign acc.bytes0 = split ? room : byteCount;
    assign acc.bytes1 = split ? (byteCount - room) : '0;

    assign acc.op = write ? opWrite : opRead;
    assign acc.fromBus = fromBus;
    assign acc.data = dataIn;

endmodule

`default_nettype wire

/* tlbLookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tlbLookup import tlbPkg::*; import alignPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    tlbWrite,
    input  logic [tlbIndexBits-1:0] tlbWriteIndex,
    input  tlbEntry                 tlbWriteEntry,
    accessIf.execute                acc,
    output logic [pfnBits-1:0]      pfn0,
    output logic [pfnBits-1:0]      pfn1,
    output logic                    miss,
    output logic                    protFault,
    output logic                    hit,
    output logic                    cacheDisable
);

    tlbEntry                 entries [tlbEntries];
    logic [tlbIndexBits:0]   find0;
    logic [tlbIndexBits:0]   find1;
    tlbEntry                 entry0;
    tlbEntry                 entry1;
    logic                    isWrite;
    logic                    miss0;
    logic                    miss1;
    logic                    fault0;
    logic                    fault1;

    // entries come up invalid, one write per strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                entries[i] <= '0;
            end
        end else if (tlbWrite) begin
            entries[tlbWriteIndex] <= tlbWriteEntry;
        end
    end

    // returns {found, index}; scanning downward leaves the lowest match
    function automatic logic [tlbIndexBits:0] findEntry(input logic [vpnBits-1:0] vpn);
        logic [tlbIndexBits:0] result;
        result = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (entries[i].valid && (entries[i].vpn == vpn)) begin
                result = {1'b1, tlbIndexBits'(i)};
            end
        end
        return result;
    endfunction

    // both lines are looked up in parallel
    always_comb begin
        find0 = findEntry(acc.vAddr0[31:pageOffsetBits]);
        find1 = findEntry(acc.vAddr1[31:pageOffsetBits]);
    end

    assign entry0 = entries[find0[tlbIndexBits-1:0]];
    assign entry1 = entries[find1[tlbIndexBits-1:0]];

    assign isWrite = (acc.op == opWrite);

    // a matching entry that is not present is still a miss
    assign miss0 = !find0[tlbIndexBits] || !entry0.present;
    assign miss1 = acc.split && (!find1[tlbIndexBits] || !entry1.present);

    assign fault0 = !miss0 && isWrite && !entry0.writable;
    assign fault1 = acc.split && !miss1 && isWrite && !entry1.writable;

    assign pfn0 = entry0.pfn;
    assign pfn1 = entry1.pfn;

    assign miss = acc.valid && (miss0 || miss1);
    assign protFault = acc.valid && (fault0 || fault1);
    assign hit = acc.valid && !miss0 && !miss1;

    // the second line only counts when it is needed
    assign cacheDisable = acc.valid &&
        ((!miss0 && entry0.cacheDisable) || (acc.split && !miss1 && entry1.cacheDisable));

endmodule

`default_nettype wire

/* lineBuild.sv */
`timescale 1ns/1ps
`default_nettype none

module lineBuild import alignPkg::*; import tlbPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    accessIf.result                 acc,
    input  logic [pfnBits-1:0]      pfn0,
    input  logic [pfnBits-1:0]      pfn1,
    input  logic                    miss,
    input  logic                    protFault,
    input  logic                    hit,
    input  logic                    cacheDisableIn,

    output logic                    valid0,
    output logic [physAddrBits-1:0] address0,
    output logic [31:0]             vAddress0,
    output logic [lineBytes-1:0]    mask0,
    output logic [dataBits-1:0]     data0,
    output accessSize               size0,
    output logic                    write0,

    output logic                    valid1,
    output logic [physAddrBits-1:0] address1,
    output logic [31:0]             vAddress1,
    output logic [lineBytes-1:0]    mask1,
    output logic [dataBits-1:0]     data1,
    output logic                    write1,

    output logic                    needP1,
    output logic                    tlbMiss,
    output logic                    protectionFault,
    output logic                    tlbHit,
    output logic                    cacheDisable
);

    logic                    good;
    logic [lineBytes-1:0]    maskNext0;
    logic [lineBytes-1:0]    maskNext1;
    logic [dataBits-1:0]     dataNext0;
    logic [dataBits-1:0]     dataNext1;
    logic [physAddrBits-1:0] addrNext0;
    logic [physAddrBits-1:0] addrNext1;
    logic                    isWrite;

    // count ones starting at byte 0
    function automatic logic [lineBytes-1:0] lowOnes(input logic [countBits-1:0] count);
        logic [lineBytes-1:0] m;
        for (int i = 0; i < lineBytes; i++) begin
            m[i] = (i < count);
        end
        return m;
    endfunction

    // bus transfers take the whole line as is
    assign maskNext0 = acc.fromBus ? '1 : (lowOnes(acc.bytes0) << acc.offset);
    assign maskNext1 = lowOnes(acc.bytes1);

    // first line moves data up to the offset lane
    assign dataNext0 = acc.fromBus ? acc.data : (acc.data << {acc.offset, 3'b000});

    // second line gets what is left after bytes0
    assign dataNext1 = acc.fromBus ? acc.data : (acc.data >> {acc.bytes0, 3'b000});

    // frame number over the page-internal line index
    assign addrNext0 = {pfn0, acc.vAddr0[pageOffsetBits-1:offsetBits], {offsetBits{1'b0}}};
    assign addrNext1 = {pfn1, acc.vAddr1[pageOffsetBits-1:offsetBits], {offsetBits{1'b0}}};

    assign good = acc.valid && !(miss || protFault);
    assign isWrite = (acc.op == opWrite);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
            tlbMiss <= 1'b0;
            protectionFault <= 1'b0;
            tlbHit <= 1'b0;
            cacheDisable <= 1'b0;
        end else begin
            valid0 <= good;
            valid1 <= good && acc.split;
            tlbMiss <= miss;
            protectionFault <= protFault;
            tlbHit <= hit;
            cacheDisable <= cacheDisableIn;
        end
    end

    // payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        address0 <= addrNext0;
        vAddress0 <= acc.vAddr0;
        mask0 <= maskNext0;
        data0 <= dataNext0;
        size0 <= acc.size0;
        write0 <= isWrite;
        address1 <= addrNext1;
        vAddress1 <= acc.vAddr1;
        mask1 <= maskNext1;
        data1 <= dataNext1;
        write1 <= isWrite;
    end

    assign needP1 = valid1;

endmodule

`default_nettype wire

/* inputAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module inputAlign import alignPkg::*; import tlbPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    validIn,
    input  logic [31:0]             addressIn,
    input  accessSize               sizeIn,
    input  logic                    sizeOvr,
    input  logic                    write,
    input  logic                    fromBus,
    input  logic [dataBits-1:0]     dataIn,
    input  logic                    tlbWrite,
    input  logic [tlbIndexBits-1:0] tlbWriteIndex,
    input  tlbEntry                 tlbWriteEntry,

    output logic                    valid0,
    output logic [physAddrBits-1:0] address0,
    output logic [31:0]             vAddress0,
    output logic [lineBytes-1:0]    mask0,
    output logic [dataBits-1:0]     data0,
    output accessSize               size0,
    output logic                    write0,

    output logic                    valid1,
    output logic [physAddrBits-1:0] address1,
    output logic [31:0]             vAddress1,
    output logic [lineBytes-1:0]    mask1,
    output logic [dataBits-1:0]     data1,
    output logic                    write1,

    output logic                    needP1,
    output logic                    tlbMiss,
    output logic                    protectionFault,
    output logic                    tlbHit,
    output logic                    cacheDisable
);

    logic [pfnBits-1:0] pfn0;
    logic [pfnBits-1:0] pfn1;
    logic               miss;
    logic               protFault;
    logic               hit;
    logic               cacheDis;

    // decoded request shared by all three stages
    accessIf acc ();

    accessDecode i_accessDecode (
        .validIn   (validIn),
        .addressIn (addressIn),
        .sizeIn    (sizeIn),
        .sizeOvr   (sizeOvr),
        .write     (write),
        .fromBus   (fromBus),
        .dataIn    (dataIn),
        .acc       (acc.decode)
    );

    tlbLookup i_tlbLookup (
        .clk           (clk),
        .rstN          (rstN),
        .tlbWrite      (tlbWrite),
        .tlbWriteIndex (tlbWriteIndex),
        .tlbWriteEntry (tlbWriteEntry),
        .acc           (acc.execute),
        .pfn0          (pfn0),
        .pfn1          (pfn1),
        .miss          (miss),
        .protFault     (protFault),
        .hit           (hit),
        .cacheDisable  (cacheDis)
    );

    // the only registered stage, one cycle from request to outputs
    lineBuild i_lineBuild (
        .clk             (clk),
        .rstN            (rstN),
        .acc             (acc.result),
        .pfn0            (pfn0),
        .pfn1            (pfn1),
        .miss            (miss),
        .protFault       (protFault),
        .hit             (hit),
        .cacheDisableIn  (cacheDis),
        .valid0          (valid0),
        .address0        (address0),
        .vAddress0       (vAddress0),
        .mask0           (mask0),
        .data0           (data0),
        .size0           (size0),
        .write0          (write0),
        .valid1          (valid1),
        .address1        (address1),
        .vAddress1       (vAddress1),
        .mask1           (mask1),
        .data1           (data1),
        .write1          (write1),
        .needP1          (needP1),
        .tlbMiss         (tlbMiss),
        .protectionFault (protectionFault),
        .tlbHit          (tlbHit),
        .cacheDisable    (cacheDisable)
    );

endmodule

`default_nettype wire

/* tbInputAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module tbInputAlign import alignPkg::*; import tlbPkg::*; ();

    localparam int resetCycles = 16;
    localparam int nonSplitCount = 300;
    localparam int splitCount = 150;
    localparam int faultCount = 200;
    localparam int busCount = 150;
    localparam int totalCycles = resetCycles + 2 + 2 * tlbEntries + nonSplitCount
        + splitCount + faultCount + busCount + 2;

    typedef struct packed {
        logic                    valid0;
        logic                    valid1;
        logic                    miss;
        logic                    fault;
        logic                    hit;
        logic                    cacheDis;
        logic [physAddrBits-1:0] addr0;
        logic [physAddrBits-1:0] addr1;
        logic [31:0]             vAddr0;
        logic [31:0]             vAddr1;
        logic [lineBytes-1:0]    mask0;
        logic [lineBytes-1:0]    mask1;
        logic [dataBits-1:0]     data0;
        logic [dataBits-1:0]     data1;
        logic [1:0]              size;
        logic                    write;
    } expectation;

    logic clk;
    logic rstN;
    logic validIn;
    logic [31:0] addressIn;
    accessSize sizeIn;
    logic sizeOvr;
    logic write;
    logic fromBus;
    logic [dataBits-1:0] dataIn;
    logic tlbWrite;
    logic [tlbIndexBits-1:0] tlbWriteIndex;
    tlbEntry tlbWriteEntry;
    logic valid0;
    logic [physAddrBits-1:0] address0;
    logic [31:0] vAddress0;
    logic [lineBytes-1:0] mask0;
    logic [dataBits-1:0] data0;
    accessSize size0;
    logic write0;
    logic valid1;
    logic [physAddrBits-1:0] address1;
    logic [31:0] vAddress1;
    logic [lineBytes-1:0] mask1;
    logic [dataBits-1:0] data1;
    logic write1;
    logic needP1;
    logic tlbMiss;
    logic protectionFault;
    logic tlbHit;
    logic cacheDisable;

    tlbEntry modelTlb [tlbEntries];
    expectation expQ[$];
    string nameQ[$];
    string testName;
    logic [vpnBits-1:0] vpnBase;
    int checkCount;
    int errorCount;

    inputAlign i_inputAlign (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run length is fixed by the test counts
    initial begin
        repeat (totalCycles + 100) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", totalCycles + 100);
        $display("Testbench failed");
        $finish;
    end

    function automatic int unsigned randRange(input int unsigned lo, input int unsigned hi);
        return lo + ($urandom % (hi - lo + 1));
    endfunction

    // one line in four sits at the top of its page
    function automatic logic [7:0] pickLine();
        if ($urandom % 4 == 0) begin
            return 8'hff;
        end
        return 8'($urandom);
    endfunction

    function automatic logic [31:0] pageAddr(input int k, input logic [7:0] line,
                                             input logic [3:0] off);
        return {vpnBase + vpnBits'(k), line, off};
    endfunction

    // lowest matching valid entry, -1 if none
    function automatic int lookupModel(input logic [vpnBits-1:0] vpn);
        int idx;
        idx = -1;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (modelTlb[i].valid && modelTlb[i].vpn == vpn) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic expectation predict(input logic v, input logic [31:0] addr,
                                           input logic [1:0] sz, input logic ovr, input logic wr,
                                           input logic bus, input logic [dataBits-1:0] d);
        expectation e;
        int n;
        int off;
        int b0;
        int b1;
        int idx0;
        int idx1;
        logic twoLines;
        logic hit0;
        logic hit1;
        logic ro0;
        logic ro1;
        logic cd0;
        logic cd1;
        logic [pfnBits-1:0] pfnA;
        logic [pfnBits-1:0] pfnB;
        e = '0;
        n = ovr ? 8 : (1 << sz);
        off = addr[3:0];
        twoLines = !bus && (off + n > lineBytes);
        b0 = twoLines ? lineBytes - off : n;
        b1 = n - b0;
        e.vAddr0 = {addr[31:4], 4'h0};
        e.vAddr1 = e.vAddr0 + 32'd16;
        {hit0, ro0, cd0, pfnA, hit1, ro1, cd1, pfnB} = '0;
        idx0 = lookupModel(e.vAddr0[31:12]);
        idx1 = lookupModel(e.vAddr1[31:12]);
        if (idx0 >= 0) begin
            hit0 = modelTlb[idx0].present;
            ro0 = !modelTlb[idx0].writable;
            cd0 = modelTlb[idx0].cacheDisable;
            pfnA = modelTlb[idx0].pfn;
        end
        if (idx1 >= 0 && twoLines) begin
            hit1 = modelTlb[idx1].present;
            ro1 = !modelTlb[idx1].writable;
            cd1 = modelTlb[idx1].cacheDisable;
            pfnB = modelTlb[idx1].pfn;
        end
        e.miss = v && (!hit0 || (twoLines && !hit1));
        e.fault = v && wr && ((hit0 && ro0) || (twoLines && hit1 && ro1));
        e.hit = v && hit0 && (!twoLines || hit1);
        e.cacheDis = v && ((hit0 && cd0) || (hit1 && cd1));
        e.valid0 = v && !e.miss && !e.fault;
        e.valid1 = e.valid0 && twoLines;
        e.addr0 = {pfnA, e.vAddr0[11:4], 4'h0};
        e.addr1 = {pfnB, e.vAddr1[11:4], 4'h0};
        e.size = ovr ? 2'd3 : sz;
        e.write = wr;
        for (int i = 0; i < lineBytes; i++) begin
            if (bus) begin
                e.mask0[i] = 1'b1;
                e.data0[i*8 +: 8] = d[i*8 +: 8];
            end else begin
                e.mask0[i] = (i >= off) && (i < off + b0);
                if (i >= off) begin
                    e.data0[i*8 +: 8] = d[(i-off)*8 +: 8];
                end
            end
            e.mask1[i] = (i < b1);
            if (i + b0 < lineBytes) begin
                e.data1[i*8 +: 8] = d[(i+b0)*8 +: 8];
            end
        end
        return e;
    endfunction

    task automatic compareField(input string name, input string field,
                                input logic [dataBits-1:0] exp, input logic [dataBits-1:0] act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("ERR %s %s: expected %h actual %h", name, field, exp, act);
        end
    endtask

    // outputs of the request driven one cycle earlier
    task automatic checkPending();
        expectation e;
        string name;
        if (expQ.size() == 0) begin
            return;
        end
        e = expQ.pop_front();
        name = nameQ.pop_front();
        compareField(name, "valid0", e.valid0, valid0);
        compareField(name, "valid1", e.valid1, valid1);
        compareField(name, "needP1", e.valid1, needP1);
        compareField(name, "tlbMiss", e.miss, tlbMiss);
        compareField(name, "protectionFault", e.fault, protectionFault);
        compareField(name, "tlbHit", e.hit, tlbHit);
        compareField(name, "cacheDisable", e.cacheDis, cacheDisable);
        if (e.valid0) begin
            compareField(name, "address0", e.addr0, address0);
            compareField(name, "vAddress0", e.vAddr0, vAddress0);
            compareField(name, "mask0", e.mask0, mask0);
            compareField(name, "data0", e.data0, data0);
            compareField(name, "size0", e.size, size0);
            compareField(name, "write0", e.write, write0);
        end
        if (e.valid1) begin
            compareField(name, "address1", e.addr1, address1);
            compareField(name, "vAddress1", e.vAddr1, vAddress1);
            compareField(name, "mask1", e.mask1, mask1);
            compareField(name, "data1", e.data1, data1);
            compareField(name, "write1", e.write, write1);
        end
    endtask

    task automatic issue(input logic v, input logic [31:0] addr, input logic [1:0] sz,
                         input logic ovr, input logic wr, input logic bus, input logic tw,
                         input logic [tlbIndexBits-1:0] twIdx, input tlbEntry twEntry);
        logic [dataBits-1:0] d;
        @(negedge clk);
        checkPending();
        d = {$urandom, $urandom, $urandom, $urandom};
        validIn = v;
        addressIn = addr;
        sizeIn = accessSize'(sz);
        sizeOvr = ovr;
        write = wr;
        fromBus = bus;
        dataIn = d;
        tlbWrite = tw;
        tlbWriteIndex = twIdx;
        tlbWriteEntry = twEntry;
        // request of this cycle still sees the old table
        expQ.push_back(predict(v, addr, sz, ovr, wr, bus, d));
        nameQ.push_back(testName);
        if (tw) begin
            modelTlb[twIdx] = twEntry;
        end
    endtask

    // entry i maps page vpnBase + i, writable and present
    task automatic mapAll();
        tlbEntry t;
        for (int i = 0; i < tlbEntries; i++) begin
            t = '0;
            t.vpn = vpnBase + vpnBits'(i);
            t.pfn = pfnBits'($urandom);
            t.valid = 1'b1;
            t.present = 1'b1;
            t.writable = 1'b1;
            t.cacheDisable = $urandom % 2;
            issue(1'b0, '0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1, tlbIndexBits'(i), t);
        end
    endtask

    initial begin
        tlbEntry t;
        int unsigned sz;
        int unsigned n;
        void'($urandom(93));
        checkCount = 0;
        errorCount = 0;
        rstN = 1'b0;
        // a live request during reset must not reach the outputs
        validIn = 1'b1;
        addressIn = '0;
        sizeIn = sz1;
        sizeOvr = 1'b0;
        write = 1'b0;
        fromBus = 1'b0;
        dataIn = '0;
        tlbWrite = 1'b0;
        tlbWriteIndex = '0;
        tlbWriteEntry = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            modelTlb[i] = '0;
        end
        repeat (resetCycles) @(negedge clk);
        testName = "reset";
        compareField(testName, "valid0", 1'b0, valid0);
        compareField(testName, "valid1", 1'b0, valid1);
        compareField(testName, "needP1", 1'b0, needP1);
        compareField(testName, "tlbMiss", 1'b0, tlbMiss);
        compareField(testName, "protectionFault", 1'b0, protectionFault);
        validIn = 1'b0;
        rstN = 1'b1;
        @(negedge clk);
        vpnBase = vpnBits'($urandom) & 20'hffff0;

        testName = "nonSplit";
        mapAll();
        repeat (nonSplitCount) begin
            sz = randRange(0, 3);
            n = 1 << sz;
            issue(1'b1, pageAddr(randRange(0, 7), pickLine(), 4'(randRange(0, 16 - n))),
                  2'(sz), 1'b0, $urandom % 2, 1'b0, 1'b0, '0, '0);
        end

        // offsets chosen so the access runs past the line end
        testName = "split";
        repeat (splitCount) begin
            sz = randRange(1, 3);
            n = 1 << sz;
            issue(1'b1, pageAddr(randRange(0, 6), pickLine(), 4'(16 - n + randRange(1, n - 1))),
                  2'(sz), 1'b0, $urandom % 2, 1'b0, 1'b0, '0, '0);
        end

        // vpnBase + 8 and + 9 are never mapped before this point
        testName = "tlbFault";
        repeat (faultCount) begin
            t = '0;
            t.vpn = vpnBase + vpnBits'(randRange(0, 9));
            t.pfn = pfnBits'($urandom);
            t.valid = ($urandom % 8 != 0);
            t.present = ($urandom % 6 != 0);
            t.writable = $urandom % 2;
            t.cacheDisable = $urandom % 2;
            issue(1'b1, pageAddr(randRange(0, 7), pickLine(), 4'($urandom)), 2'($urandom),
                  1'b0, $urandom % 2, 1'b0, ($urandom % 3 == 0), tlbIndexBits'($urandom), t);
        end

        testName = "busOvr";
        mapAll();
        repeat (busCount) begin
            issue(1'b1, pageAddr(randRange(0, 6), pickLine(), 4'($urandom)), 2'($urandom),
                  $urandom % 2, $urandom % 2, $urandom % 2, 1'b0, '0, '0);
        end
        issue(1'b0, '0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        checkPending();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
alignPkg.sv
tlbPkg.sv
accessIf.sv
accessDecode.sv
tlbLookup.sv
lineBuild.sv
inputAlign.sv
tbInputAlign.sv
